// ==== verilog/tile_pkg.sv ====
//////////////////////////////
// Tile bus widths, RAM geometry and AXI field values
// Opcode and FSM state enums of the accumulator core
//////////////////////////////

package tile_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;
  localparam int STRB_W = DATA_W / 8;

  // RAM geometry, one word per entry
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

  // Single-beat AXI field values
  localparam logic [7:0]      AXI_LEN_SINGLE  = 8'd0;
  localparam logic [2:0]      AXI_SIZE_WORD   = 3'd2;
  localparam logic [1:0]      AXI_BURST_INCR  = 2'b01;
  localparam logic [1:0]      AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0]      AXI_RESP_SLVERR = 2'b10;
  // Core issues every request with this ID
  localparam logic [ID_W-1:0] CORE_ID         = '0;

  // Instruction opcode, bits 31:28
  typedef enum logic [3:0] {
    OP_HALT  = 4'd0,
    OP_LOAD  = 4'd1,
    OP_ADD   = 4'd2,
    OP_STORE = 4'd3,
    OP_HART  = 4'd4,
    OP_DEC   = 4'd5,
    OP_JNZ   = 4'd6
  } opcode_e;

  // Core FSM
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_FETCH_AR,
    ST_FETCH_R,
    ST_EXEC,
    ST_LD_AR,
    ST_LD_R,
    ST_ST_AW,
    ST_ST_B,
    ST_HALT
  } core_state_e;

endpackage

// ==== verilog/accum_core.sv ====
//////////////////////////////
// Accumulator core with fetch/execute FSM
// Single-beat AXI4 master for fetch, load and store
//////////////////////////////

`timescale 1ns/1ns

module accum_core (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          go_i,
  input  logic [tile_pkg::ADDR_W-1:0]   boot_addr_i,
  input  logic [tile_pkg::DATA_W-1:0]   hart_id_i,
  // AW channel
  output logic                          awvalid_o,
  input  logic                          awready_i,
  output logic [tile_pkg::ADDR_W-1:0]   awaddr_o,
  output logic [tile_pkg::ID_W-1:0]     awid_o,
  output logic [7:0]                    awlen_o,
  output logic [2:0]                    awsize_o,
  output logic [1:0]                    awburst_o,
  // W channel
  output logic                          wvalid_o,
  input  logic                          wready_i,
  output logic [tile_pkg::DATA_W-1:0]   wdata_o,
  output logic [tile_pkg::STRB_W-1:0]   wstrb_o,
  output logic                          wlast_o,
  // B channel
  input  logic                          bvalid_i,
  output logic                          bready_o,
  input  logic [1:0]                    bresp_i,
  input  logic [tile_pkg::ID_W-1:0]     bid_i,
  // AR channel
  output logic                          arvalid_o,
  input  logic                          arready_i,
  output logic [tile_pkg::ADDR_W-1:0]   araddr_o,
  output logic [tile_pkg::ID_W-1:0]     arid_o,
  output logic [7:0]                    arlen_o,
  output logic [2:0]                    arsize_o,
  output logic [1:0]                    arburst_o,
  // R channel
  input  logic                          rvalid_i,
  output logic                          rready_o,
  input  logic [tile_pkg::DATA_W-1:0]   rdata_i,
  input  logic [1:0]                    rresp_i,
  input  logic [tile_pkg::ID_W-1:0]     rid_i,
  input  logic                          rlast_i,
  // Status
  output logic                          halt_o,
  output logic [tile_pkg::DATA_W-1:0]   acc_o,
  output logic [tile_pkg::ADDR_W-1:0]   pc_o
);

  tile_pkg::core_state_e state_q;
  tile_pkg::opcode_e     opcode;
  logic [tile_pkg::DATA_W-1:0] acc_q;
  logic [tile_pkg::ADDR_W-1:0] pc_q;
  logic [tile_pkg::DATA_W-1:0] instr_q;
  logic                        aw_done_q;
  logic                        w_done_q;
  logic [tile_pkg::ADDR_W-1:0] opnd_addr;
  logic [tile_pkg::ADDR_W-1:0] pc_next;
  logic                        aw_hs;
  logic                        w_hs;
  logic                        ar_hs;
  logic                        r_hs;
  logic                        b_hs;
  logic                        r_fault;
  logic                        b_fault;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign opcode = tile_pkg::opcode_e'(instr_q[31:28]);
  // Operand is a word index, bus wants bytes
  assign opnd_addr = {{(tile_pkg::ADDR_W-tile_pkg::MEM_AW-2){1'b0}},
                      instr_q[tile_pkg::MEM_AW-1:0], 2'b00};
  assign pc_next = pc_q + {{(tile_pkg::ADDR_W-3){1'b0}}, 3'd4};

  // Handshakes
  assign aw_hs = awvalid_o & awready_i;
  assign w_hs  = wvalid_o & wready_i;
  assign ar_hs = arvalid_o & arready_i;
  assign r_hs  = rvalid_i & rready_o;
  assign b_hs  = bvalid_i & bready_o;

  // Error response, foreign ID or missing last beat
  assign r_fault = (rresp_i != tile_pkg::AXI_RESP_OKAY) | (rid_i != tile_pkg::CORE_ID) |
                   ~rlast_i;
  assign b_fault = (bresp_i != tile_pkg::AXI_RESP_OKAY) | (bid_i != tile_pkg::CORE_ID);

  //////////////////////////////
  // AXI master outputs
  //////////////////////////////

  // Read address is the pc for a fetch, the operand for a load
  assign arvalid_o = (state_q == tile_pkg::ST_FETCH_AR) | (state_q == tile_pkg::ST_LD_AR);
  assign araddr_o  = (state_q == tile_pkg::ST_LD_AR) ? opnd_addr : pc_q;
  assign arid_o    = tile_pkg::CORE_ID;
  assign arlen_o   = tile_pkg::AXI_LEN_SINGLE;
  assign arsize_o  = tile_pkg::AXI_SIZE_WORD;
  assign arburst_o = tile_pkg::AXI_BURST_INCR;
  assign rready_o  = (state_q == tile_pkg::ST_FETCH_R) | (state_q == tile_pkg::ST_LD_R);

  // AW and W rise together, each drops after its own handshake
  assign awvalid_o = (state_q == tile_pkg::ST_ST_AW) & ~aw_done_q;
  assign awaddr_o  = opnd_addr;
  assign awid_o    = tile_pkg::CORE_ID;
  assign awlen_o   = tile_pkg::AXI_LEN_SINGLE;
  assign awsize_o  = tile_pkg::AXI_SIZE_WORD;
  assign awburst_o = tile_pkg::AXI_BURST_INCR;
  assign wvalid_o  = (state_q == tile_pkg::ST_ST_AW) & ~w_done_q;
  assign wdata_o   = acc_q;
  assign wstrb_o   = '1;
  assign wlast_o   = 1'b1;
  assign bready_o  = (state_q == tile_pkg::ST_ST_B);

  // Status
  assign halt_o = (state_q == tile_pkg::ST_HALT);
  assign acc_o  = acc_q;
  assign pc_o   = pc_q;

  //////////////////////////////
  // FSM and datapath
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= tile_pkg::ST_IDLE;
      acc_q     <= '0;
      pc_q      <= '0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        tile_pkg::ST_IDLE, tile_pkg::ST_HALT: begin
          // Start or restart, accumulator is kept
          if (go_i) begin
            pc_q    <= boot_addr_i;
            state_q <= tile_pkg::ST_FETCH_AR;
          end
        end
        tile_pkg::ST_FETCH_AR: begin
          if (ar_hs) state_q <= tile_pkg::ST_FETCH_R;
        end
        tile_pkg::ST_FETCH_R: begin
          // A bus fault parks the core
          if (r_hs) state_q <= r_fault ? tile_pkg::ST_HALT : tile_pkg::ST_EXEC;
        end
        tile_pkg::ST_EXEC: begin
          case (opcode)
            tile_pkg::OP_LOAD, tile_pkg::OP_ADD: begin
              state_q <= tile_pkg::ST_LD_AR;
            end
            tile_pkg::OP_STORE: begin
              aw_done_q <= 1'b0;
              w_done_q  <= 1'b0;
              state_q   <= tile_pkg::ST_ST_AW;
            end
            tile_pkg::OP_HART: begin
              acc_q   <= hart_id_i;
              pc_q    <= pc_next;
              state_q <= tile_pkg::ST_FETCH_AR;
            end
            tile_pkg::OP_DEC: begin
              acc_q   <= acc_q - {{(tile_pkg::DATA_W-1){1'b0}}, 1'b1};
              pc_q    <= pc_next;
              state_q <= tile_pkg::ST_FETCH_AR;
            end
            tile_pkg::OP_JNZ: begin
              pc_q    <= (acc_q != '0) ? opnd_addr : pc_next;
              state_q <= tile_pkg::ST_FETCH_AR;
            end
            // HALT and unknown opcodes, pc stays on this instruction
            default: state_q <= tile_pkg::ST_HALT;
          endcase
        end
        tile_pkg::ST_LD_AR: begin
          if (ar_hs) state_q <= tile_pkg::ST_LD_R;
        end
        tile_pkg::ST_LD_R: begin
          if (r_hs) begin
            if (r_fault) begin
              state_q <= tile_pkg::ST_HALT;
            end else begin
              // Same read path serves LOAD and ADD
              acc_q   <= (opcode == tile_pkg::OP_ADD) ? acc_q + rdata_i : rdata_i;
              pc_q    <= pc_next;
              state_q <= tile_pkg::ST_FETCH_AR;
            end
          end
        end
        tile_pkg::ST_ST_AW: begin
          if (aw_hs) aw_done_q <= 1'b1;
          if (w_hs) w_done_q <= 1'b1;
          if ((aw_done_q | aw_hs) & (w_done_q | w_hs)) state_q <= tile_pkg::ST_ST_B;
        end
        tile_pkg::ST_ST_B: begin
          if (b_hs) begin
            pc_q    <= b_fault ? pc_q : pc_next;
            state_q <= b_fault ? tile_pkg::ST_HALT : tile_pkg::ST_FETCH_AR;
          end
        end
        default: state_q <= tile_pkg::ST_IDLE;
      endcase
    end
  end

  // Instruction latch
  always_ff @(posedge clk_i) begin
    if (state_q == tile_pkg::ST_FETCH_R && r_hs) instr_q <= rdata_i;
  end

endmodule

// ==== verilog/axi_sram.sv ====
//////////////////////////////
// Single-beat AXI4 slave RAM
// Side load port and combinational peek port
//////////////////////////////

`timescale 1ns/1ns

module axi_sram (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // AW channel
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [tile_pkg::ADDR_W-1:0]   awaddr_i,
  input  logic [tile_pkg::ID_W-1:0]     awid_i,
  input  logic [7:0]                    awlen_i,
  input  logic [2:0]                    awsize_i,
  input  logic [1:0]                    awburst_i,
  // W channel
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [tile_pkg::DATA_W-1:0]   wdata_i,
  input  logic [tile_pkg::STRB_W-1:0]   wstrb_i,
  input  logic                          wlast_i,
  // B channel
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output logic [1:0]                    bresp_o,
  output logic [tile_pkg::ID_W-1:0]     bid_o,
  // AR channel
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [tile_pkg::ADDR_W-1:0]   araddr_i,
  input  logic [tile_pkg::ID_W-1:0]     arid_i,
  input  logic [7:0]                    arlen_i,
  input  logic [2:0]                    arsize_i,
  input  logic [1:0]                    arburst_i,
  // R channel
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [tile_pkg::DATA_W-1:0]   rdata_o,
  output logic [1:0]                    rresp_o,
  output logic [tile_pkg::ID_W-1:0]     rid_o,
  output logic                          rlast_o,
  // Load and peek ports
  input  logic                          load_we_i,
  input  logic [tile_pkg::MEM_AW-1:0]   load_addr_i,
  input  logic [tile_pkg::DATA_W-1:0]   load_data_i,
  input  logic [tile_pkg::MEM_AW-1:0]   peek_addr_i,
  output logic [tile_pkg::DATA_W-1:0]   peek_data_o
);

  logic [tile_pkg::DATA_W-1:0] mem [tile_pkg::MEM_WORDS];
  logic                        bvalid_q;
  logic [1:0]                  bresp_q;
  logic [tile_pkg::ID_W-1:0]   bid_q;
  logic                        rvalid_q;
  logic [1:0]                  rresp_q;
  logic [tile_pkg::ID_W-1:0]   rid_q;
  logic [tile_pkg::DATA_W-1:0] rdata_q;
  logic                        wr_fire;
  logic                        rd_fire;
  logic                        wr_legal;
  logic                        rd_legal;
  logic [tile_pkg::MEM_AW-1:0] wr_idx;
  logic [tile_pkg::MEM_AW-1:0] rd_idx;

  // Word index from byte address, upper bits wrap
  assign wr_idx = awaddr_i[tile_pkg::MEM_AW+1:2];
  assign rd_idx = araddr_i[tile_pkg::MEM_AW+1:2];

  // Only single-beat word INCR requests are served
  assign wr_legal = (awlen_i == tile_pkg::AXI_LEN_SINGLE) &
                    (awsize_i == tile_pkg::AXI_SIZE_WORD) &
                    (awburst_i == tile_pkg::AXI_BURST_INCR) & wlast_i;
  assign rd_legal = (arlen_i == tile_pkg::AXI_LEN_SINGLE) &
                    (arsize_i == tile_pkg::AXI_SIZE_WORD) &
                    (arburst_i == tile_pkg::AXI_BURST_INCR);

  //////////////////////////////
  // Write path
  //////////////////////////////

  // AW and W are taken in the same cycle; ready drops while only one is up
  assign awready_o = ~bvalid_q & ~(awvalid_i ^ wvalid_i);
  assign wready_o  = awready_o;
  assign wr_fire   = awvalid_i & wvalid_i & ~bvalid_q;

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign bid_o    = bid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  // Response payload follows the accepted request
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bid_q   <= awid_i;
      bresp_q <= wr_legal ? tile_pkg::AXI_RESP_OKAY : tile_pkg::AXI_RESP_SLVERR;
    end
  end

  // Storage, load port wins over AXI
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end else if (wr_fire && wr_legal) begin
      for (int b = 0; b < tile_pkg::STRB_W; b++) begin
        if (wstrb_i[b]) mem[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  // One read response in flight at most
  assign arready_o = ~rvalid_q;
  assign rd_fire   = arvalid_i & arready_o;

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;
  assign rid_o    = rid_q;
  // Every beat is the last one
  assign rlast_o  = rvalid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= mem[rd_idx];
      rid_q   <= arid_i;
      rresp_q <= rd_legal ? tile_pkg::AXI_RESP_OKAY : tile_pkg::AXI_RESP_SLVERR;
    end
  end

  // Debug view of the array
  assign peek_data_o = mem[peek_addr_i];

endmodule

// ==== verilog/tile_top.sv ====
//////////////////////////////
// Tile top, core AXI master wired to the RAM slave
//////////////////////////////

`timescale 1ns/1ns

module tile_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          go_i,
  input  logic [tile_pkg::ADDR_W-1:0]   boot_addr_i,
  input  logic [tile_pkg::DATA_W-1:0]   hart_id_i,
  // RAM load and peek
  input  logic                          load_we_i,
  input  logic [tile_pkg::MEM_AW-1:0]   load_addr_i,
  input  logic [tile_pkg::DATA_W-1:0]   load_data_i,
  input  logic [tile_pkg::MEM_AW-1:0]   peek_addr_i,
  output logic [tile_pkg::DATA_W-1:0]   peek_data_o,
  // Core status
  output logic                          halt_o,
  output logic [tile_pkg::DATA_W-1:0]   acc_o,
  output logic [tile_pkg::ADDR_W-1:0]   pc_o
);

  // Write channels
  logic                        awvalid;
  logic                        awready;
  logic [tile_pkg::ADDR_W-1:0] awaddr;
  logic [tile_pkg::ID_W-1:0]   awid;
  logic [7:0]                  awlen;
  logic [2:0]                  awsize;
  logic [1:0]                  awburst;
  logic                        wvalid;
  logic                        wready;
  logic [tile_pkg::DATA_W-1:0] wdata;
  logic [tile_pkg::STRB_W-1:0] wstrb;
  logic                        wlast;
  logic                        bvalid;
  logic                        bready;
  logic [1:0]                  bresp;
  logic [tile_pkg::ID_W-1:0]   bid;
  // Read channels
  logic                        arvalid;
  logic                        arready;
  logic [tile_pkg::ADDR_W-1:0] araddr;
  logic [tile_pkg::ID_W-1:0]   arid;
  logic [7:0]                  arlen;
  logic [2:0]                  arsize;
  logic [1:0]                  arburst;
  logic                        rvalid;
  logic                        rready;
  logic [tile_pkg::DATA_W-1:0] rdata;
  logic [1:0]                  rresp;
  logic [tile_pkg::ID_W-1:0]   rid;
  logic                        rlast;

  // Stand-in core, sole bus master
  accum_core u_core (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .go_i        (go_i),
    .boot_addr_i (boot_addr_i),
    .hart_id_i   (hart_id_i),
    .awvalid_o   (awvalid),
    .awready_i   (awready),
    .awaddr_o    (awaddr),
    .awid_o      (awid),
    .awlen_o     (awlen),
    .awsize_o    (awsize),
    .awburst_o   (awburst),
    .wvalid_o    (wvalid),
    .wready_i    (wready),
    .wdata_o     (wdata),
    .wstrb_o     (wstrb),
    .wlast_o     (wlast),
    .bvalid_i    (bvalid),
    .bready_o    (bready),
    .bresp_i     (bresp),
    .bid_i       (bid),
    .arvalid_o   (arvalid),
    .arready_i   (arready),
    .araddr_o    (araddr),
    .arid_o      (arid),
    .arlen_o     (arlen),
    .arsize_o    (arsize),
    .arburst_o   (arburst),
    .rvalid_i    (rvalid),
    .rready_o    (rready),
    .rdata_i     (rdata),
    .rresp_i     (rresp),
    .rid_i       (rid),
    .rlast_i     (rlast),
    .halt_o      (halt_o),
    .acc_o       (acc_o),
    .pc_o        (pc_o)
  );

  // Program and data RAM
  axi_sram u_sram (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .awvalid_i   (awvalid),
    .awready_o   (awready),
    .awaddr_i    (awaddr),
    .awid_i      (awid),
    .awlen_i     (awlen),
    .awsize_i    (awsize),
    .awburst_i   (awburst),
    .wvalid_i    (wvalid),
    .wready_o    (wready),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .wlast_i     (wlast),
    .bvalid_o    (bvalid),
    .bready_i    (bready),
    .bresp_o     (bresp),
    .bid_o       (bid),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .araddr_i    (araddr),
    .arid_i      (arid),
    .arlen_i     (arlen),
    .arsize_i    (arsize),
    .arburst_i   (arburst),
    .rvalid_o    (rvalid),
    .rready_i    (rready),
    .rdata_o     (rdata),
    .rresp_o     (rresp),
    .rid_o       (rid),
    .rlast_o     (rlast),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .peek_addr_i (peek_addr_i),
    .peek_data_o (peek_data_o)
  );

endmodule

// ==== dv/tb_clock.sv ====
//////////////////////////////
// Testbench clock, 100 ns period
// Synchronous reset held for 5 cycles
//////////////////////////////

`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset released on a falling edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== dv/tile_asserts.sv ====
//////////////////////////////
// AXI master handshake checks
// Bound into every accum_core
//////////////////////////////

`timescale 1ns/1ns

module tile_asserts (
  input logic                          clk_i,
  input logic                          rst_i,
  input tile_pkg::core_state_e         state_i,
  input logic                          awvalid_i,
  input logic                          awready_i,
  input logic [tile_pkg::ADDR_W-1:0]   awaddr_i,
  input logic                          wvalid_i,
  input logic                          wready_i,
  input logic [tile_pkg::DATA_W-1:0]   wdata_i,
  input logic                          arvalid_i,
  input logic                          arready_i,
  input logic [tile_pkg::ADDR_W-1:0]   araddr_i
);

  logic parked;

  // No bus activity expected in these states
  assign parked = (state_i == tile_pkg::ST_IDLE) | (state_i == tile_pkg::ST_HALT);

  //////////////////////////////
  // Valid held with stable payload
  //////////////////////////////

  aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("awvalid dropped or awaddr changed before handshake");

  w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else $error("wvalid dropped or wdata changed before handshake");

  ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("arvalid dropped or araddr changed before handshake");

  //////////////////////////////
  // Write request pairing
  //////////////////////////////

  aw_w_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(awvalid_i) |-> $rose(wvalid_i))
    else $error("awvalid rose without wvalid");

  w_aw_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(wvalid_i) |-> $rose(awvalid_i))
    else $error("wvalid rose without awvalid");

  // Idle or halted core keeps the bus quiet
  parked_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    parked |-> !(awvalid_i || wvalid_i || arvalid_i))
    else $error("valid raised while core idle or halted");

endmodule

bind accum_core tile_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .state_i   (state_q),
  .awvalid_i (awvalid_o),
  .awready_i (awready_i),
  .awaddr_i  (awaddr_o),
  .wvalid_i  (wvalid_o),
  .wready_i  (wready_i),
  .wdata_i   (wdata_o),
  .arvalid_i (arvalid_o),
  .arready_i (arready_i),
  .araddr_i  (araddr_o)
);

// ==== dv/tile_tb.sv ====
//////////////////////////////
// Tile testbench, fixed program with a table of operand rows
// LFSR rows, typed compare tasks and a watchdog
//////////////////////////////

`timescale 1ns/1ns

module tile_tb;

  localparam int CLK_PERIOD = 100;
  localparam int N_FIXED    = 2;
  localparam int N_RAND     = 4;
  localparam int ROWS       = N_FIXED + N_RAND;
  // Margin covers reset and program load
  localparam int WATCHDOG_CYCLES = ROWS * 200 + 40;
  localparam int PROG_WORDS = 8;
  localparam int HALT_WORD  = 7;
  localparam logic [7:0] X_WORD    = 8'd64;
  localparam logic [7:0] Y_WORD    = 8'd65;
  localparam logic [7:0] SUM_WORD  = 8'd66;
  localparam logic [7:0] HART_WORD = 8'd67;

  logic                        clk;
  logic                        rst;
  logic                        go_i;
  logic [tile_pkg::ADDR_W-1:0] boot_addr_i;
  logic [tile_pkg::DATA_W-1:0] hart_id_i;
  logic                        load_we_i;
  logic [tile_pkg::MEM_AW-1:0] load_addr_i;
  logic [tile_pkg::DATA_W-1:0] load_data_i;
  logic [tile_pkg::MEM_AW-1:0] peek_addr_i;
  logic [tile_pkg::DATA_W-1:0] peek_data_o;
  logic                        halt_o;
  logic [tile_pkg::DATA_W-1:0] acc_o;
  logic [tile_pkg::ADDR_W-1:0] pc_o;

  // Stimulus and expected values, one entry per row
  logic [tile_pkg::DATA_W-1:0] x_tab        [ROWS];
  logic [tile_pkg::DATA_W-1:0] y_tab        [ROWS];
  logic [tile_pkg::DATA_W-1:0] hart_tab     [ROWS];
  logic [tile_pkg::DATA_W-1:0] exp_sum_tab  [ROWS];
  logic [tile_pkg::DATA_W-1:0] exp_hart_tab [ROWS];
  logic [tile_pkg::DATA_W-1:0] exp_acc_tab  [ROWS];
  logic [tile_pkg::DATA_W-1:0] prog         [PROG_WORDS];
  logic [19:0]                 lfsr_q;

  tb_clock u_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  tile_top DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .go_i        (go_i),
    .boot_addr_i (boot_addr_i),
    .hart_id_i   (hart_id_i),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .peek_addr_i (peek_addr_i),
    .peek_data_o (peek_data_o),
    .halt_o      (halt_o),
    .acc_o       (acc_o),
    .pc_o        (pc_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Opcode in 31:28, word operand in 7:0
  function automatic logic [31:0] encode(input tile_pkg::opcode_e op, input logic [7:0] word);
    return {op, 20'd0, word};
  endfunction

  // x^20 + x^17 + 1, new bit enters at bit 0
  function automatic logic [19:0] lfsr_next(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [tile_pkg::DATA_W-1:0] got,
                            input logic [tile_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [tile_pkg::ADDR_W-1:0] got,
                            input logic [tile_pkg::ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Called on a falling edge, returns on the next one
  task automatic load_word(input logic [7:0] addr, input logic [31:0] data);
    load_we_i   = 1'b1;
    load_addr_i = addr;
    load_data_i = data;
    @(negedge clk);
    load_we_i   = 1'b0;
  endtask

  task automatic peek_check(input string name, input logic [7:0] addr,
                            input logic [31:0] exp);
    peek_addr_i = addr;
    @(negedge clk);
    check_word(name, peek_data_o, exp);
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout, core never halted within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [31:0] v;

    go_i        = 1'b0;
    boot_addr_i = '0;
    hart_id_i   = '0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    peek_addr_i = '0;
    lfsr_q      = 20'd78042;

    prog[0] = encode(tile_pkg::OP_LOAD, X_WORD);
    prog[1] = encode(tile_pkg::OP_ADD, Y_WORD);
    prog[2] = encode(tile_pkg::OP_STORE, SUM_WORD);
    prog[3] = encode(tile_pkg::OP_HART, 8'd0);
    prog[4] = encode(tile_pkg::OP_STORE, HART_WORD);
    prog[5] = encode(tile_pkg::OP_DEC, 8'd0);
    prog[6] = encode(tile_pkg::OP_JNZ, 8'd5);
    prog[7] = encode(tile_pkg::OP_HALT, 8'd0);

    // Overflow row, then a plain one
    x_tab[0] = 32'hFFFF_FFFF;
    y_tab[0] = 32'h0000_0002;
    hart_tab[0] = 32'd1;
    x_tab[1] = 32'h1234_5678;
    y_tab[1] = 32'h0FED_CBA9;
    hart_tab[1] = 32'd10;
    for (int r = N_FIXED; r < ROWS; r++) begin
      draw_bits(32, x_tab[r]);
      draw_bits(32, y_tab[r]);
      // Hart of zero would make the countdown wrap
      do begin
        draw_bits(4, v);
      end while (v == 0);
      hart_tab[r] = v;
    end
    for (int r = 0; r < ROWS; r++) begin
      exp_sum_tab[r]  = x_tab[r] + y_tab[r];
      exp_hart_tab[r] = hart_tab[r];
      // DEC/JNZ counts a nonzero hart down to zero
      exp_acc_tab[r]  = '0;
    end

    // Wait out reset, then check the reset state
    @(negedge clk);
    while (rst) @(negedge clk);
    check_flag("halt_o", halt_o, 1'b0);
    check_word("acc_o", acc_o, '0);
    check_addr("pc_o", pc_o, '0);

    for (int i = 0; i < PROG_WORDS; i++) begin
      load_word(i[7:0], prog[i]);
    end

    // Every row after the first is a restart without reset
    for (int r = 0; r < ROWS; r++) begin
      load_word(X_WORD, x_tab[r]);
      load_word(Y_WORD, y_tab[r]);
      load_word(SUM_WORD, '0);
      load_word(HART_WORD, '0);
      hart_id_i = hart_tab[r];
      go_i = 1'b1;
      @(negedge clk);
      go_i = 1'b0;
      while (!halt_o) @(negedge clk);
      check_word("acc_o", acc_o, exp_acc_tab[r]);
      check_addr("pc_o", pc_o, HALT_WORD * 4);
      peek_check("mem[66]", SUM_WORD, exp_sum_tab[r]);
      peek_check("mem[67]", HART_WORD, exp_hart_tab[r]);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/tile_pkg.sv
verilog/accum_core.sv
verilog/axi_sram.sv
verilog/tile_top.sv
dv/tb_clock.sv
dv/tile_asserts.sv
dv/tile_tb.sv
